//--- testbench/fixed_matrix3x4_asserts.sv
module fixed_matrix3x4_asserts
	import fixed_fmt_pkg::*, xform_ctrl_pkg::*;
(
	input logic              clk,
	input logic              arst_n,
	input logic              s_ready,
	input logic              m_valid,
	input logic              m_ready,
	input logic [user_w-1:0] m_user,
	input out_t              m_x,
	input out_t              m_y,
	input out_t              m_z
);

	int fail_count = 0;	// Bumped by every failing property

	// Output register is cleared asynchronously
	assert property (@(posedge clk) !arst_n |-> !m_valid)
		else begin
			$error("m_valid high while reset is asserted");
			fail_count++;
		end

	// A held result stays until it is taken
	assert property (@(posedge clk) disable iff (!arst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_user) && $stable(m_x)
			&& $stable(m_y) && $stable(m_z))
		else begin
			$error("output changed while m_ready was low");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		m_valid && !m_ready |-> !s_ready)
		else begin
			$error("s_ready high while the output is stalled");
			fail_count++;
		end

endmodule

//--- testbench/tb_fixed_matrix3x4.sv
module tb_fixed_matrix3x4
	import fixed_fmt_pkg::*, xform_ctrl_pkg::*;
();

	typedef struct packed {
		out_t x;
		out_t y;
		out_t z;
	} res_t;

	typedef struct packed {
		logic [user_w-1:0] user;
		res_t res;
		int cycle;	// Edge count at acceptance
	} expect_t;

	logic clk;
	logic arst_n;
	logic coeff_we;
	logic [coeff_addr_w-1:0] coeff_addr;
	coeff_t coeff_data;
	logic s_valid;
	logic [user_w-1:0] s_user;
	in_t s_x, s_y, s_z;
	logic s_ready;
	logic m_valid;
	logic [user_w-1:0] m_user;
	out_t m_x, m_y, m_z;
	logic m_ready;

	integer seed;
	coeff_t mat [coeff_rows][coeff_cols];	// Model of the coefficient bank
	expect_t exp_q [$];
	string test_name;
	int cycle;
	bit accepted;
	bit stall_on;
	bit check_latency;
	bit held;
	expect_t held_out;
	in_t px, py, pz;
	coeff_t c_min, c_max;
	in_t in_min, in_max;

	fixed_matrix3x4 dut0 (.*);

	bind fixed_matrix3x4 fixed_matrix3x4_asserts asserts0 (
		.clk, .arst_n, .s_ready, .m_valid, .m_ready, .m_user, .m_x, .m_y, .m_z
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic res_t ref_xform(input coeff_t m [coeff_rows][coeff_cols],
			input in_t x, input in_t y, input in_t z);
		longint acc [coeff_rows];
		res_t r;
		for (int i = 0; i < coeff_rows; i++) begin
			// Offset goes onto the product point first
			acc[i] = longint'(m[i][0]) * x + longint'(m[i][1]) * y + longint'(m[i][2]) * z
				+ (longint'(m[i][3]) <<< in_frac_w);
			acc[i] = acc[i] >>> align_shift;
		end
		r.x = out_t'(acc[0]);	// Low bits only
		r.y = out_t'(acc[1]);
		r.z = out_t'(acc[2]);
		return r;
	endfunction

	task automatic check_value(input string what, input logic signed [63:0] expected,
			input logic signed [63:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic stop_run(input string reason);
		$display("ERROR in test %s: %s", test_name, reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic step();
		@(posedge clk);
		accepted = s_valid && s_ready;
		#5;
		m_ready = stall_on ? ($random(seed) % 4 != 0) : 1'b1;
	endtask

	task automatic write_coeff(input int addr, input coeff_t data);
		coeff_we = 1'b1;
		coeff_addr = coeff_addr_w'(addr);
		coeff_data = data;
		if (addr / coeff_cols < coeff_rows) begin
			mat[addr / coeff_cols][addr % coeff_cols] = data;
		end
		step();
		coeff_we = 1'b0;
	endtask

	task automatic send_point(input logic [user_w-1:0] user, input in_t x, input in_t y,
			input in_t z);
		int waited;
		waited = 0;
		s_valid = 1'b1;
		s_user = user;
		s_x = x;
		s_y = y;
		s_z = z;
		step();
		// Full rate stream takes a point on every edge
		if (check_latency) check_value("accept", 1, accepted);
		while (!accepted) begin
			waited++;
			if (waited > 100) stop_run("input point was never accepted");
			step();
		end
		s_valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > 500) stop_run("outstanding results never came out");
			step();
		end
	endtask

	always @(posedge clk) begin : record_inputs
		expect_t e;
		if (arst_n && s_valid && s_ready) begin
			e.user = s_user;
			e.res = ref_xform(mat, s_x, s_y, s_z);
			e.cycle = cycle;
			exp_q.push_back(e);
		end
	end

	always @(posedge clk) begin : compare_outputs
		expect_t e;
		if (arst_n) begin
			if (held) begin	// Stalled on the previous edge
				check_value("stall m_valid", 1, m_valid);
				check_value("stall m_user", held_out.user, m_user);
				check_value("stall m_x", held_out.res.x, m_x);
				check_value("stall m_y", held_out.res.y, m_y);
				check_value("stall m_z", held_out.res.z, m_z);
			end
			if (m_valid && m_ready) begin
				if (exp_q.size() == 0) begin
					stop_run("a result came out with no point outstanding");
				end else begin
					e = exp_q.pop_front();
					check_value("m_user", e.user, m_user);
					check_value("m_x", e.res.x, m_x);
					check_value("m_y", e.res.y, m_y);
					check_value("m_z", e.res.z, m_z);
					// Result was loaded one edge before it is taken
					if (check_latency) check_value("latency", 6, cycle - 1 - e.cycle);
				end
			end
			held = m_valid && !m_ready;
			held_out.user = m_user;
			held_out.res.x = m_x;
			held_out.res.y = m_y;
			held_out.res.z = m_z;
		end
	end

	initial begin
		seed = 32'ha454;
		arst_n = 1'b0;
		coeff_we = 1'b0;
		coeff_addr = '0;
		coeff_data = '0;
		s_valid = 1'b0;
		s_user = '0;
		s_x = '0;
		s_y = '0;
		s_z = '0;
		m_ready = 1'b1;
		foreach (mat[r, c]) begin
			mat[r][c] = '0;
		end
		test_name = "reset";
		repeat (10) @(posedge clk);
		#5;
		arst_n = 1'b1;
		check_value("m_valid", 0, m_valid);
		check_value("s_ready", 1, s_ready);

		// 1.0 in Q17.8 on the diagonal
		test_name = "identity";
		for (int r = 0; r < coeff_rows; r++) begin
			write_coeff(r * coeff_cols + r, coeff_t'(1) <<< coeff_frac_w);
		end
		send_point(8'h01, 1, 2, 3);
		send_point(8'h02, -5, 100, -65536);
		send_point(8'h03, 65535, 0, -1);
		drain();

		test_name = "stream";
		for (int a = 0; a < coeff_rows * coeff_cols; a++) begin
			write_coeff(a, coeff_t'($random(seed)));
		end
		check_latency = 1'b1;
		for (int i = 0; i < 40; i++) begin
			px = in_t'($random(seed));
			py = in_t'($random(seed));
			pz = in_t'($random(seed));
			send_point(user_w'(i), px, py, pz);
		end
		drain();
		check_latency = 1'b0;

		test_name = "stall";
		stall_on = 1'b1;
		for (int i = 0; i < 60; i++) begin
			repeat ($unsigned($random(seed)) % 3) step();	// Gap on s_valid
			px = in_t'($random(seed));
			py = in_t'($random(seed));
			pz = in_t'($random(seed));
			send_point(user_w'(i + 64), px, py, pz);
		end
		drain();
		stall_on = 1'b0;
		m_ready = 1'b1;

		// Row 1 with its offset, then an address past the matrix
		test_name = "rewrite";
		for (int a = 4; a < 8; a++) begin
			write_coeff(a, coeff_t'($random(seed)));
		end
		write_coeff(13, coeff_t'(25'h0abcde));
		for (int i = 0; i < 10; i++) begin
			px = in_t'($random(seed));
			py = in_t'($random(seed));
			pz = in_t'($random(seed));
			send_point(user_w'(i + 160), px, py, pz);
		end
		drain();

		test_name = "extremes";
		c_min = {1'b1, {(coeff_w-1){1'b0}}};
		c_max = ~c_min;
		in_min = {1'b1, {(in_w-1){1'b0}}};
		in_max = ~in_min;
		for (int a = 0; a < coeff_rows * coeff_cols; a++) begin
			write_coeff(a, (a < 4) ? c_min : (a < 8) ? c_max : ((a % 2) ? c_max : c_min));
		end
		for (int i = 0; i < 8; i++) begin
			send_point(user_w'(i + 200), i[0] ? in_max : in_min, i[1] ? in_max : in_min,
				i[2] ? in_max : in_min);
		end
		send_point(8'hff, 0, 0, 0);	// Offsets alone
		drain();

		// No stray result once the pipeline has emptied
		repeat (pipe_stages + 2) step();
		check_value("idle m_valid", 0, m_valid);

		if (dut0.asserts0.fail_count != 0) begin
			stop_run("a bound assertion failed");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- verilog.f
verilog/fixed_fmt_pkg.sv
verilog/xform_ctrl_pkg.sv
verilog/xform_stage_if.sv
verilog/xform_pipe_ctrl.sv
verilog/coeff_bank.sv
verilog/mul_add3.sv
verilog/fixed_matrix3x4.sv
testbench/fixed_matrix3x4_asserts.sv
testbench/tb_fixed_matrix3x4.sv

//--- verilog/coeff_bank.sv
module coeff_bank
	import fixed_fmt_pkg::*, xform_ctrl_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,

	input  logic                    coeff_we,
	input  logic [coeff_addr_w-1:0] coeff_addr,
	input  coeff_t                  coeff_data,

	output coeff_t                  row0 [coeff_cols],
	output coeff_t                  row1 [coeff_cols],
	output coeff_t                  row2 [coeff_cols]
);

	coeff_t mat [coeff_rows][coeff_cols];

	logic [coeff_addr_w-coeff_col_w-1:0] wr_row;
	logic [coeff_col_w-1:0] wr_col;
	logic wr_hit;

	assign wr_row = coeff_addr[coeff_addr_w-1:coeff_col_w];
	assign wr_col = coeff_addr[coeff_col_w-1:0];
	assign wr_hit = coeff_we && (wr_row < coeff_rows);	// Row 3 does not exist

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < coeff_rows; r++) begin
				for (int c = 0; c < coeff_cols; c++) begin
					mat[r][c] <= '0;
				end
			end
		end else if (wr_hit) begin
			mat[wr_row][wr_col] <= coeff_data;
		end
	end

	// Column 3 of each row is the offset
	assign row0 = mat[0];
	assign row1 = mat[1];
	assign row2 = mat[2];

endmodule

//--- verilog/fixed_fmt_pkg.sv
package fixed_fmt_pkg;

	// Coefficients in Q17.8
	localparam int coeff_int_w = 17;
	localparam int coeff_frac_w = 8;
	localparam int coeff_w = coeff_int_w + coeff_frac_w;

	// Input points are plain integers
	localparam int in_int_w = 17;
	localparam int in_frac_w = 0;
	localparam int in_w = in_int_w + in_frac_w;

	localparam int out_int_w = 17;
	localparam int out_frac_w = 8;
	localparam int out_w = out_int_w + out_frac_w;

	localparam int prod_w = coeff_w + in_w;

	// Right shift from product point to output point, must not go negative
	localparam int align_shift = coeff_frac_w + in_frac_w - out_frac_w;

	typedef logic signed [coeff_w-1:0] coeff_t;
	typedef logic signed [in_w-1:0] in_t;
	typedef logic signed [out_w-1:0] out_t;
	typedef logic signed [prod_w-1:0] prod_t;

endpackage

//--- verilog/fixed_matrix3x4.sv
module fixed_matrix3x4
	import fixed_fmt_pkg::*, xform_ctrl_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,

	input  logic                    coeff_we,
	input  logic [coeff_addr_w-1:0] coeff_addr,
	input  coeff_t                  coeff_data,

	input  logic                    s_valid,
	input  logic [user_w-1:0]       s_user,
	input  in_t                     s_x,
	input  in_t                     s_y,
	input  in_t                     s_z,
	output logic                    s_ready,

	output logic                    m_valid,
	output logic [user_w-1:0]       m_user,
	output out_t                    m_x,
	output out_t                    m_y,
	output out_t                    m_z,
	input  logic                    m_ready
);

	coeff_t row0 [coeff_cols];
	coeff_t row1 [coeff_cols];
	coeff_t row2 [coeff_cols];

	out_t sink_x;
	out_t sink_y;
	out_t sink_z;

	xform_stage_if stage_bus ();

	xform_pipe_ctrl ctrl0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.s_valid (s_valid),
		.s_user  (s_user),
		.s_x     (s_x),
		.s_y     (s_y),
		.s_z     (s_z),
		.s_ready (s_ready),
		.stage   (stage_bus),
		.sink_x  (sink_x),
		.sink_y  (sink_y),
		.sink_z  (sink_z),
		.m_valid (m_valid),
		.m_user  (m_user),
		.m_x     (m_x),
		.m_y     (m_y),
		.m_z     (m_z),
		.m_ready (m_ready)
	);

	coeff_bank bank0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.coeff_we   (coeff_we),
		.coeff_addr (coeff_addr),
		.coeff_data (coeff_data),
		.row0       (row0),
		.row1       (row1),
		.row2       (row2)
	);

	// One lane per output row
	mul_add3 lane_x (
		.clk (clk), .arst_n (arst_n), .stage (stage_bus),
		.a (row0[0]), .b (row0[1]), .c (row0[2]), .d (row0[3]), .p (sink_x)
	);

	mul_add3 lane_y (
		.clk (clk), .arst_n (arst_n), .stage (stage_bus),
		.a (row1[0]), .b (row1[1]), .c (row1[2]), .d (row1[3]), .p (sink_y)
	);

	mul_add3 lane_z (
		.clk (clk), .arst_n (arst_n), .stage (stage_bus),
		.a (row2[0]), .b (row2[1]), .c (row2[2]), .d (row2[3]), .p (sink_z)
	);

endmodule

//--- verilog/mul_add3.sv
module mul_add3
	import fixed_fmt_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,

	xform_stage_if.lane stage,

	input  coeff_t      a,
	input  coeff_t      b,
	input  coeff_t      c,
	input  coeff_t      d,

	output out_t        p
);

	coeff_t st0_a, st0_b, st0_c, st0_d;
	in_t st0_x, st0_y, st0_z;
	prod_t st1_ax, st1_by, st1_cz, st1_d;
	prod_t st2_ax, st2_by, st2_cz, st2_d;
	prod_t st3_sum;
	out_t st4_p;

	always_ff @(posedge clk) begin
		if (stage.stage_cke[0]) begin
			st0_a <= a;
			st0_b <= b;
			st0_c <= c;
			st0_d <= d;
			st0_x <= stage.src_x;
			st0_y <= stage.src_y;
			st0_z <= stage.src_z;
		end
		if (stage.stage_cke[1]) begin
			// Operands sign extend to the full product width
			st1_ax <= st0_a * st0_x;
			st1_by <= st0_b * st0_y;
			st1_cz <= st0_c * st0_z;
			st1_d <= st0_d;
		end
		if (stage.stage_cke[2]) begin
			st2_ax <= st1_ax;	// Second multiplier stage
			st2_by <= st1_by;
			st2_cz <= st1_cz;
			st2_d <= st1_d;
		end
		if (stage.stage_cke[3]) begin
			// Offset moved onto the product's fractional point, sum wraps at prod_w
			st3_sum <= st2_ax + st2_by + st2_cz + (st2_d <<< in_frac_w);
		end
	end

	// Result reads zero out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st4_p <= '0;
		end else if (stage.stage_cke[4]) begin
			st4_p <= out_t'(st3_sum >>> align_shift);	// Plain truncation
		end
	end

	assign p = st4_p;

endmodule

//--- verilog/xform_ctrl_pkg.sv
package xform_ctrl_pkg;

	// Lane depth, the output register comes on top of this
	localparam int pipe_stages = 5;

	// Coefficient at (row, col) sits at row*4 + col
	localparam int coeff_addr_w = 4;
	localparam int coeff_rows = 3;
	localparam int coeff_cols = 4;
	localparam int coeff_col_w = $clog2(coeff_cols);

	localparam int user_w = 8;

	// Output register occupancy
	typedef enum logic {
		out_empty,
		out_full
	} out_state_t;

endpackage

//--- verilog/xform_pipe_ctrl.sv
module xform_pipe_ctrl
	import fixed_fmt_pkg::*, xform_ctrl_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,

	input  logic              s_valid,
	input  logic [user_w-1:0] s_user,
	input  in_t               s_x,
	input  in_t               s_y,
	input  in_t               s_z,
	output logic              s_ready,

	xform_stage_if.ctrl       stage,

	input  out_t              sink_x,
	input  out_t              sink_y,
	input  out_t              sink_z,

	output logic              m_valid,
	output logic [user_w-1:0] m_user,
	output out_t              m_x,
	output out_t              m_y,
	output out_t              m_z,
	input  logic              m_ready
);

	logic advance;
	out_state_t out_state;

	logic src_valid;
	logic [user_w-1:0] src_user;
	logic [pipe_stages-1:0] stage_valid;
	logic [user_w-1:0] stage_user [pipe_stages];

	// Whole pipeline moves unless a full output register is held
	assign advance = (out_state == out_empty) || m_ready;
	assign s_ready = advance;
	assign stage.stage_cke = {pipe_stages{advance}};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			src_valid <= 1'b0;
			stage_valid <= '0;
		end else if (advance) begin
			src_valid <= s_valid;	// Bubble when nothing offered
			stage_valid <= {stage_valid[pipe_stages-2:0], src_valid};
		end
	end

	// Input register and tag delay line, in step with the lanes
	always_ff @(posedge clk) begin
		if (advance) begin
			src_user <= s_user;
			stage.src_x <= s_x;
			stage.src_y <= s_y;
			stage.src_z <= s_z;
			stage_user[0] <= src_user;
			for (int i = 1; i < pipe_stages; i++) begin
				stage_user[i] <= stage_user[i-1];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_state <= out_empty;
		end else if (advance) begin
			// Invalid last stage empties the register, bubbles are dropped here
			out_state <= stage_valid[pipe_stages-1] ? out_full : out_empty;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && stage_valid[pipe_stages-1]) begin
			m_user <= stage_user[pipe_stages-1];
			m_x <= sink_x;
			m_y <= sink_y;
			m_z <= sink_z;
		end
	end

	assign m_valid = (out_state == out_full);

endmodule

//--- verilog/xform_stage_if.sv
interface xform_stage_if
	import fixed_fmt_pkg::*, xform_ctrl_pkg::*;
();

	logic [pipe_stages-1:0] stage_cke;	// One enable per lane stage

	// Registered point, shared by all lanes
	in_t src_x;
	in_t src_y;
	in_t src_z;

	modport ctrl (
		output stage_cke,
		output src_x,
		output src_y,
		output src_z
	);

	modport lane (
		input stage_cke,
		input src_x,
		input src_y,
		input src_z
	);

endinterface
